//--- logic/bayerGray.sv
/*
  Bayer to gray. Each 2x2 quad is averaged into one gray pixel,
  emitted on the sample at odd row and odd column.
*/
`timescale 1ns/1ps

module bayerGray (
  input  logic                 D5M_PIXLCLK,
  input  logic                 rstN,
  input  sensorPkg::rawPixel   rawIn,
  input  logic                 rawValid,
  input  sensorPkg::pixelCoord column,
  input  sensorPkg::pixelCoord row,
  output filterPkg::grayPixel  grayOut,
  output logic                 grayValid
);

  // Even rows kept for the upper half of the quad
  sensorPkg::rawPixel lineMem [sensorPkg::rawLineLength];
  sensorPkg::rawPixel prevSample;
  logic [$clog2(sensorPkg::rawLineLength)-1:0] colAddr;
  logic [$clog2(sensorPkg::rawLineLength)-1:0] leftAddr;
  logic [13:0] quadSum;
  logic        quadDone;

  assign colAddr  = column[$clog2(sensorPkg::rawLineLength)-1:0];
  assign leftAddr = {colAddr[$clog2(sensorPkg::rawLineLength)-1:1], 1'b0};
  assign quadDone = rawValid && row[0] && column[0];

  assign quadSum = 14'(lineMem[leftAddr]) + 14'(lineMem[colAddr])
                 + 14'(prevSample) + 14'(rawIn);

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rawValid)
    begin
      prevSample <= rawIn;
      if (!row[0])
        lineMem[colAddr] <= rawIn;
    end
    // Truncating divide by 4
    if (quadDone)
      grayOut <= quadSum[13:2];
  end

  always_ff @(posedge D5M_PIXLCLK or negedge rstN)
  begin
    if (!rstN)
      grayValid <= 1'b0;
    else
      grayValid <= quadDone;
  end

endmodule

//--- logic/cameraFilterTop.sv
/*
  Camera filter path top level. Capture, gray conversion, Gaussian,
  then edge and Laplacian filters; mode picks the registered output view.
*/
`timescale 1ns/1ps

module cameraFilterTop (
  input  logic                 D5M_PIXLCLK,
  input  logic                 rstN,
  input  sensorPkg::rawPixel   sensorData,
  input  logic                 frameValid,
  input  logic                 lineValid,
  input  logic                 captureStart,
  input  logic                 captureEnd,
  input  filterPkg::viewMode   mode,
  output filterPkg::grayPixel  viewPixel,
  output logic                 viewValid,
  output sensorPkg::frameCount frameTotal,
  output logic                 capturing
);

  sensorPkg::rawPixel   rawOut;
  logic                 rawValid;
  sensorPkg::pixelCoord column;
  sensorPkg::pixelCoord row;
  logic                 frameStart;
  filterPkg::grayPixel  grayOut;
  logic                 grayValid;
  filterPkg::grayWindow gaussWindow;
  logic                 gaussWindowValid;
  filterPkg::grayPixel  gaussOut;
  logic                 gaussValid;
  filterPkg::grayWindow edgeWindow;
  logic                 edgeWindowValid;
  filterPkg::grayPixel  vertEdge;
  filterPkg::grayPixel  horizEdge;
  filterPkg::grayPixel  laplace;
  logic                 edgeValid;
  filterPkg::grayPixel  selPixel;
  logic                 selValid;

  // ====================
  // Pipeline
  // ====================
  frameCapture capture (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .sensorData(sensorData),
    .frameValid(frameValid), .lineValid(lineValid),
    .captureStart(captureStart), .captureEnd(captureEnd),
    .rawOut(rawOut), .rawValid(rawValid), .column(column), .row(row),
    .frameStart(frameStart), .frameTotal(frameTotal), .capturing(capturing)
  );

  bayerGray gray (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .rawIn(rawOut), .rawValid(rawValid),
    .column(column), .row(row), .grayOut(grayOut), .grayValid(grayValid)
  );

  windowBuffer #(.lineLength(sensorPkg::grayLineLength)) gaussLines (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .frameStart(frameStart),
    .pixelIn(grayOut), .pixelValid(grayValid),
    .window(gaussWindow), .windowValid(gaussWindowValid)
  );

  gaussianBlur gauss (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .window(gaussWindow),
    .windowValid(gaussWindowValid), .gaussOut(gaussOut), .gaussValid(gaussValid)
  );

  // Blurred lines are two pixels shorter
  windowBuffer #(.lineLength(sensorPkg::grayLineLength - 2)) edgeLines (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .frameStart(frameStart),
    .pixelIn(gaussOut), .pixelValid(gaussValid),
    .window(edgeWindow), .windowValid(edgeWindowValid)
  );

  edgeLaplace edges (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .window(edgeWindow),
    .windowValid(edgeWindowValid), .vertEdge(vertEdge), .horizEdge(horizEdge),
    .laplace(laplace), .edgeValid(edgeValid)
  );

  // ====================
  // View select
  // ====================
  always_comb
  begin
    selPixel = '0;
    selValid = 1'b0;
    case (mode)
      filterPkg::viewGray:
      begin
        selPixel = grayOut;
        selValid = grayValid;
      end
      filterPkg::viewGauss:
      begin
        selPixel = gaussOut;
        selValid = gaussValid;
      end
      filterPkg::viewVertEdge:
      begin
        selPixel = vertEdge;
        selValid = edgeValid;
      end
      filterPkg::viewHorizEdge:
      begin
        selPixel = horizEdge;
        selValid = edgeValid;
      end
      filterPkg::viewBothEdge:
      begin
        selPixel = vertEdge | horizEdge;
        selValid = edgeValid;
      end
      filterPkg::viewLaplace:
      begin
        selPixel = laplace;
        selValid = edgeValid;
      end
      default:
      begin
        selPixel = '0;
        selValid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (selValid)
      viewPixel <= selPixel;
  end

  always_ff @(posedge D5M_PIXLCLK or negedge rstN)
  begin
    if (!rstN)
      viewValid <= 1'b0;
    else
      viewValid <= selValid;
  end

endmodule

//--- logic/edgeLaplace.sv
/*
  Sobel column and row gradients plus the 8-neighbour Laplacian,
  all as saturated magnitudes from one shared 3x3 window.
*/
`timescale 1ns/1ps

module edgeLaplace (
  input  logic                 D5M_PIXLCLK,
  input  logic                 rstN,
  input  filterPkg::grayWindow window,
  input  logic                 windowValid,
  output filterPkg::grayPixel  vertEdge,
  output filterPkg::grayPixel  horizEdge,
  output filterPkg::grayPixel  laplace,
  output logic                 edgeValid
);

  logic signed [17:0] sx [9];
  logic signed [17:0] vertSum;
  logic signed [17:0] horizSum;
  logic signed [17:0] lapSum;

  // Absolute value, clipped to the pixel range
  function automatic filterPkg::grayPixel clampMag(input logic signed [17:0] value);
    logic [17:0] mag;
    mag = value[17] ? 18'(-value) : 18'(value);
    if (mag > 18'(filterPkg::grayMax))
      return filterPkg::grayMax;
    return filterPkg::grayPixel'(mag);
  endfunction

  always_comb
  begin
    for (int i = 0; i < 9; i++)
      sx[i] = 18'(window[(8 - i) * $bits(filterPkg::grayPixel) +: $bits(filterPkg::grayPixel)]);
  end

  // ====================
  // Kernels
  // ====================
  // Right column minus left column
  assign vertSum = (sx[2] + (sx[5] <<< 1) + sx[8]) - (sx[0] + (sx[3] <<< 1) + sx[6]);

  // Bottom row minus top row
  assign horizSum = (sx[6] + (sx[7] <<< 1) + sx[8]) - (sx[0] + (sx[1] <<< 1) + sx[2]);

  assign lapSum = (sx[4] <<< 3)
                - (sx[0] + sx[1] + sx[2] + sx[3] + sx[5] + sx[6] + sx[7] + sx[8]);

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (windowValid)
    begin
      vertEdge  <= clampMag(vertSum);
      horizEdge <= clampMag(horizSum);
      laplace   <= clampMag(lapSum);
    end
  end

  always_ff @(posedge D5M_PIXLCLK or negedge rstN)
  begin
    if (!rstN)
      edgeValid <= 1'b0;
    else
      edgeValid <= windowValid;
  end

endmodule

//--- logic/filterPkg.sv
/*
  Filter side definitions: gray sample and 3x3 window types, the
  output view selection and the Gaussian normalisation.
*/
package filterPkg;

  typedef logic [11:0] grayPixel;

  // Nine samples, row-major, top-left in the most significant slice
  typedef logic [107:0] grayWindow;

  // Saturation value for edge and Laplacian magnitudes
  localparam grayPixel grayMax = 12'hfff;

  // Kernel weights of the 1-2-1 Gaussian sum to 16
  localparam int gaussShift = 4;

  typedef enum logic [2:0] {
    viewGray,
    viewGauss,
    viewVertEdge,
    viewHorizEdge,
    viewBothEdge,
    viewLaplace
  } viewMode;

endpackage

//--- logic/frameCapture.sv
/*
  Sensor front end. Registers the D5M data and strobes, gates capture
  with start/end pulses and tags each captured sample with its column,
  row and a per-frame start pulse.
*/
`timescale 1ns/1ps

module frameCapture (
  input  logic                 D5M_PIXLCLK,
  input  logic                 rstN,
  input  sensorPkg::rawPixel   sensorData,
  input  logic                 frameValid,
  input  logic                 lineValid,
  input  logic                 captureStart,
  input  logic                 captureEnd,
  output sensorPkg::rawPixel   rawOut,
  output logic                 rawValid,
  output sensorPkg::pixelCoord column,
  output sensorPkg::pixelCoord row,
  output logic                 frameStart,
  output sensorPkg::frameCount frameTotal,
  output logic                 capturing
);

  sensorPkg::rawPixel   dataReg;
  logic                 fvalReg;
  logic                 lvalReg;
  logic                 startReg;
  logic                 endReg;
  logic                 fvalPrev;
  logic                 lvalPrev;
  logic                 startPending;
  logic                 endPending;
  sensorPkg::pixelCoord colCount;
  sensorPkg::pixelCoord rowCount;
  logic                 frameRise;
  logic                 frameFall;
  logic                 lineFall;
  logic                 sampleValid;

  assign frameRise   = fvalReg && !fvalPrev;
  assign frameFall   = !fvalReg && fvalPrev;
  assign lineFall    = !lvalReg && lvalPrev;
  assign sampleValid = fvalReg && lvalReg;

  // Sample path, one register stage per side
  always_ff @(posedge D5M_PIXLCLK)
  begin
    dataReg <= sensorData;
    rawOut  <= dataReg;
    if (sampleValid)
    begin
      column <= colCount;
      row    <= rowCount;
    end
  end

  always_ff @(posedge D5M_PIXLCLK or negedge rstN)
  begin
    if (!rstN)
    begin
      fvalReg      <= 1'b0;
      lvalReg      <= 1'b0;
      startReg     <= 1'b0;
      endReg       <= 1'b0;
      fvalPrev     <= 1'b0;
      lvalPrev     <= 1'b0;
      startPending <= 1'b0;
      endPending   <= 1'b0;
      capturing    <= 1'b0;
      frameStart   <= 1'b0;
      rawValid     <= 1'b0;
      frameTotal   <= '0;
      colCount     <= '0;
      rowCount     <= '0;
    end
    else
    begin
      fvalReg  <= frameValid;
      lvalReg  <= lineValid;
      startReg <= captureStart;
      endReg   <= captureEnd;
      fvalPrev <= fvalReg;
      lvalPrev <= lvalReg;

      // ====================
      // Capture control
      // ====================
      // Requests wait for the next frame boundary
      startPending <= startReg || (startPending && !frameRise);
      endPending   <= endReg || (endPending && !frameFall);
      if (frameRise && startPending)
        capturing <= 1'b1;
      else if (frameFall && endPending)
        capturing <= 1'b0;

      frameStart <= frameRise && (capturing || startPending);
      rawValid   <= capturing && sampleValid;
      if (frameFall && capturing)
        frameTotal <= frameTotal + 1'b1;

      // Column and row counters
      if (!fvalReg)
      begin
        colCount <= '0;
        rowCount <= '0;
      end
      else if (sampleValid)
        colCount <= colCount + 1'b1;
      else if (lineFall)
      begin
        colCount <= '0;
        rowCount <= rowCount + 1'b1;
      end
    end
  end

endmodule

//--- logic/gaussianBlur.sv
/*
  3x3 Gaussian blur with the 1-2-1 kernel, normalised by a shift.
*/
`timescale 1ns/1ps

module gaussianBlur (
  input  logic                 D5M_PIXLCLK,
  input  logic                 rstN,
  input  filterPkg::grayWindow window,
  input  logic                 windowValid,
  output filterPkg::grayPixel  gaussOut,
  output logic                 gaussValid
);

  filterPkg::grayPixel px [9];
  logic [15:0]         weighted;

  // px[0] is top-left, px[8] bottom-right
  always_comb
  begin
    for (int i = 0; i < 9; i++)
      px[i] = window[(8 - i) * $bits(filterPkg::grayPixel) +: $bits(filterPkg::grayPixel)];
  end

  // Corners x1, edges x2, centre x4
  assign weighted = 16'(px[0]) + 16'(px[2]) + 16'(px[6]) + 16'(px[8])
                  + ((16'(px[1]) + 16'(px[3]) + 16'(px[5]) + 16'(px[7])) << 1)
                  + (16'(px[4]) << 2);

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (windowValid)
      gaussOut <= filterPkg::grayPixel'(weighted >> filterPkg::gaussShift);
  end

  always_ff @(posedge D5M_PIXLCLK or negedge rstN)
  begin
    if (!rstN)
      gaussValid <= 1'b0;
    else
      gaussValid <= windowValid;
  end

endmodule

//--- logic/sensorPkg.sv
/*
  Sensor side definitions: sample, coordinate and counter widths
  plus the line geometry of the incoming Bayer stream.
*/
package sensorPkg;

  // ====================
  // Sample and counter types
  // ====================
  typedef logic [11:0] rawPixel;
  typedef logic [15:0] pixelCoord;
  typedef logic [31:0] frameCount;

  // ====================
  // Line geometry
  // ====================
  // Simulation sized, the sensor delivers 1280 samples per line
  localparam int rawLineLength = 32;

  // One gray pixel per 2x2 Bayer quad
  localparam int grayLineLength = rawLineLength / 2;

endpackage

//--- logic/windowBuffer.sv
/*
  Line buffered 3x3 window. Two delayed lines feed three column
  shift registers; a window is flagged only when fully inside the frame.
*/
`timescale 1ns/1ps

module windowBuffer #(
  parameter int lineLength = sensorPkg::grayLineLength
) (
  input  logic                 D5M_PIXLCLK,
  input  logic                 rstN,
  input  logic                 frameStart,
  input  filterPkg::grayPixel  pixelIn,
  input  logic                 pixelValid,
  output filterPkg::grayWindow window,
  output logic                 windowValid
);

  filterPkg::grayPixel lineOne [lineLength];
  filterPkg::grayPixel lineTwo [lineLength];
  filterPkg::grayPixel topTap [3];
  filterPkg::grayPixel midTap [3];
  filterPkg::grayPixel botTap [3];
  logic [$clog2(lineLength)-1:0] colCount;
  sensorPkg::pixelCoord          rowCount;
  logic                          lastColumn;

  assign lastColumn = (colCount == $clog2(lineLength)'(lineLength - 1));

  // Index 2 holds the newest column
  assign window = {topTap[0], topTap[1], topTap[2],
                   midTap[0], midTap[1], midTap[2],
                   botTap[0], botTap[1], botTap[2]};

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (pixelValid)
    begin
      lineTwo[colCount] <= lineOne[colCount];
      lineOne[colCount] <= pixelIn;
      for (int i = 0; i < 2; i++)
      begin
        topTap[i] <= topTap[i + 1];
        midTap[i] <= midTap[i + 1];
        botTap[i] <= botTap[i + 1];
      end
      topTap[2] <= lineTwo[colCount];
      midTap[2] <= lineOne[colCount];
      botTap[2] <= pixelIn;
    end
  end

  always_ff @(posedge D5M_PIXLCLK or negedge rstN)
  begin
    if (!rstN)
    begin
      colCount    <= '0;
      rowCount    <= '0;
      windowValid <= 1'b0;
    end
    else
    begin
      windowValid <= pixelValid && (colCount >= 2) && (rowCount >= 2);
      if (frameStart)
      begin
        colCount <= '0;
        rowCount <= '0;
      end
      else if (pixelValid)
      begin
        if (lastColumn)
        begin
          colCount <= '0;
          rowCount <= rowCount + 1'b1;
        end
        else
          colCount <= colCount + 1'b1;
      end
    end
  end

endmodule

//--- sim/cameraFilterTb.sv
/*
  Testbench for cameraFilterTop. Sends random Bayer frames, with a bright
  cross in the edge view frames, builds the gray, Gaussian, Sobel and Laplacian
  images in a model and checks every output pixel plus capture start and end.
*/
`timescale 1ns/1ps

module cameraFilterTb;

  localparam int rawRows    = 12;
  localparam int grayRows   = rawRows / 2;
  localparam int grayCols   = sensorPkg::grayLineLength;
  localparam int gaussRows  = grayRows - 2;
  localparam int gaussCols  = grayCols - 2;
  localparam int driveDelay = 20;

  logic                 D5M_PIXLCLK;
  logic                 rstN;
  sensorPkg::rawPixel   sensorData;
  logic                 frameValid;
  logic                 lineValid;
  logic                 captureStart;
  logic                 captureEnd;
  filterPkg::viewMode   mode;
  filterPkg::grayPixel  viewPixel;
  logic                 viewValid;
  sensorPkg::frameCount frameTotal;
  logic                 capturing;

  // Reference images
  int rawImg [rawRows][sensorPkg::rawLineLength];
  int grayImg [grayRows][grayCols];
  int gaussImg [gaussRows][gaussCols];
  filterPkg::grayPixel expected [grayRows * grayCols];

  integer seed = 32'hf600_15c7;
  string  testName;
  int     expectedCount;
  int     outIndex;
  int     baseIndex;
  int     outPos;
  int     testErrors;
  int     passCount;
  int     failCount;
  int     capturedFrames;

  pixelClockGen clockGen (.D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN));

  cameraFilterTop uut (
    .D5M_PIXLCLK(D5M_PIXLCLK), .rstN(rstN), .sensorData(sensorData),
    .frameValid(frameValid), .lineValid(lineValid),
    .captureStart(captureStart), .captureEnd(captureEnd), .mode(mode),
    .viewPixel(viewPixel), .viewValid(viewValid),
    .frameTotal(frameTotal), .capturing(capturing)
  );

  // ====================
  // Output monitor
  // ====================
  // Sampled mid-cycle between clock and stimulus edges
  always @(negedge D5M_PIXLCLK)
  begin
    if (rstN && viewValid)
    begin
      outPos = outIndex - baseIndex;
      assert (outPos < expectedCount)
      else
      begin
        $display("%s: view pixel %0d arrived but only %0d were expected",
                 testName, outPos, expectedCount);
        testErrors++;
      end
      if (outPos < expectedCount)
        assert (viewPixel == expected[outPos])
        else
        begin
          $display("FAILED %s pixel %0d expected %h actual %h",
                   testName, outPos, expected[outPos], viewPixel);
          testErrors++;
        end
      outIndex++;
    end
  end

  // ====================
  // Reference model
  // ====================
  function automatic int weight(input int offset);
    return (offset == 0) ? 2 : 1;
  endfunction

  function automatic int magnitude(input int value);
    int mag;
    mag = (value < 0) ? -value : value;
    return (mag > int'(filterPkg::grayMax)) ? int'(filterPkg::grayMax) : mag;
  endfunction

  function automatic int gaussAt(input int r, input int c);
    int sum;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++)
      for (int dc = -1; dc <= 1; dc++)
        sum += weight(dr) * weight(dc) * grayImg[r + dr][c + dc];
    return sum >> filterPkg::gaussShift;
  endfunction

  // Right column minus left column
  function automatic int sobelVert(input int r, input int c);
    int sum;
    sum = 0;
    for (int d = -1; d <= 1; d++)
      sum += weight(d) * (gaussImg[r + d][c + 1] - gaussImg[r + d][c - 1]);
    return sum;
  endfunction

  // Bottom row minus top row
  function automatic int sobelHoriz(input int r, input int c);
    int sum;
    sum = 0;
    for (int d = -1; d <= 1; d++)
      sum += weight(d) * (gaussImg[r + 1][c + d] - gaussImg[r - 1][c + d]);
    return sum;
  endfunction

  function automatic int laplaceAt(input int r, input int c);
    int sum;
    sum = 9 * gaussImg[r][c];
    for (int dr = -1; dr <= 1; dr++)
      for (int dc = -1; dc <= 1; dc++)
        sum -= gaussImg[r + dr][c + dc];
    return sum;
  endfunction

  // Edge frames put one bright gray row and column on a dark noisy ground
  task automatic makeFrame(input bit edgeFrame);
    int noise;
    bit bright;
    for (int r = 0; r < rawRows; r++)
      for (int c = 0; c < sensorPkg::rawLineLength; c++)
      begin
        noise  = $random(seed) & 32'hfff;
        bright = (r / 2 == 3) || (c / 2 == grayCols / 2);
        if (!edgeFrame)
          rawImg[r][c] = noise;
        else if (bright)
          rawImg[r][c] = 32'hfff - (noise & 32'h3f);
        else
          rawImg[r][c] = noise & 32'h3f;
      end
    for (int r = 0; r < grayRows; r++)
      for (int c = 0; c < grayCols; c++)
        grayImg[r][c] = (rawImg[2 * r][2 * c] + rawImg[2 * r][2 * c + 1]
                       + rawImg[2 * r + 1][2 * c] + rawImg[2 * r + 1][2 * c + 1]) >> 2;
    for (int r = 0; r < gaussRows; r++)
      for (int c = 0; c < gaussCols; c++)
        gaussImg[r][c] = gaussAt(r + 1, c + 1);
  endtask

  task automatic buildExpected(input filterPkg::viewMode view, input bit captured);
    int vert;
    int horiz;
    int pixel;
    expectedCount = 0;
    if (captured && view == filterPkg::viewGray)
    begin
      for (int r = 0; r < grayRows; r++)
        for (int c = 0; c < grayCols; c++)
        begin
          expected[expectedCount] = filterPkg::grayPixel'(grayImg[r][c]);
          expectedCount++;
        end
    end
    else if (captured && view == filterPkg::viewGauss)
    begin
      for (int r = 0; r < gaussRows; r++)
        for (int c = 0; c < gaussCols; c++)
        begin
          expected[expectedCount] = filterPkg::grayPixel'(gaussImg[r][c]);
          expectedCount++;
        end
    end
    else if (captured)
    begin
      for (int r = 1; r < gaussRows - 1; r++)
        for (int c = 1; c < gaussCols - 1; c++)
        begin
          vert  = magnitude(sobelVert(r, c));
          horiz = magnitude(sobelHoriz(r, c));
          case (view)
            filterPkg::viewVertEdge:  pixel = vert;
            filterPkg::viewHorizEdge: pixel = horiz;
            filterPkg::viewBothEdge:  pixel = vert | horiz;
            default:                  pixel = magnitude(laplaceAt(r, c));
          endcase
          expected[expectedCount] = filterPkg::grayPixel'(pixel);
          expectedCount++;
        end
    end
  endtask

  // ====================
  // Stimulus and checks
  // ====================
  task automatic stepCycle();
    @(posedge D5M_PIXLCLK);
    #(driveDelay);
  endtask

  task automatic pulseStart();
    captureStart = 1'b1;
    stepCycle();
    captureStart = 1'b0;
    repeat (3) stepCycle();
  endtask

  task automatic sendFrame(input bit endMid);
    frameValid = 1'b1;
    repeat (3) stepCycle();
    for (int r = 0; r < rawRows; r++)
    begin
      lineValid = 1'b1;
      for (int c = 0; c < sensorPkg::rawLineLength; c++)
      begin
        sensorData = sensorPkg::rawPixel'(rawImg[r][c]);
        stepCycle();
      end
      lineValid  = 1'b0;
      sensorData = '0;
      // End request in the first line gap
      captureEnd = endMid && (r == 0);
      stepCycle();
      captureEnd = 1'b0;
      repeat (3) stepCycle();
    end
    frameValid = 1'b0;
    repeat (12) stepCycle();
  endtask

  task automatic checkValue(input string what, input int expectedValue, input int actualValue);
    assert (actualValue == expectedValue)
    else
    begin
      $display("FAILED %s %s expected %0d actual %0d",
               testName, what, expectedValue, actualValue);
      testErrors++;
    end
  endtask

  task automatic waitOutputs();
    int cycles;
    cycles = 0;
    while ((outIndex - baseIndex) < expectedCount && cycles < 200)
    begin
      stepCycle();
      cycles++;
    end
    if ((outIndex - baseIndex) < expectedCount)
    begin
      $display("%s: timed out waiting for the view pixels of the frame", testName);
      testErrors++;
    end
  endtask

  task automatic waitFrameTotal(input int target);
    int cycles;
    cycles = 0;
    while (int'(frameTotal) != target && cycles < 20)
    begin
      stepCycle();
      cycles++;
    end
    if (int'(frameTotal) != target)
    begin
      $display("%s: timed out waiting for the frame counter to settle", testName);
      testErrors++;
    end
  endtask

  task automatic beginTest(input string name);
    testName      = name;
    testErrors    = 0;
    expectedCount = 0;
    baseIndex     = outIndex;
  endtask

  task automatic endTest();
    if (testErrors == 0)
    begin
      $display("PASS %s", testName);
      passCount++;
    end
    else
    begin
      $display("FAIL %s with %0d errors", testName, testErrors);
      failCount++;
    end
  endtask

  task automatic runFrame(input string name, input filterPkg::viewMode view,
                          input bit captured, input bit endMid);
    bit edgeFrame;
    edgeFrame = (view != filterPkg::viewGray) && (view != filterPkg::viewGauss);
    beginTest(name);
    mode = view;
    makeFrame(edgeFrame);
    buildExpected(view, captured);
    if (captured)
      capturedFrames++;
    sendFrame(endMid);
    waitOutputs();
    checkValue("pixel count", expectedCount, outIndex - baseIndex);
    waitFrameTotal(capturedFrames);
    checkValue("frameTotal", capturedFrames, int'(frameTotal));
    checkValue("capturing", int'(captured && !endMid), int'(capturing));
    endTest();
  endtask

  initial
  begin
    int cycles;
    sensorData     = '0;
    frameValid     = 1'b0;
    lineValid      = 1'b0;
    captureStart   = 1'b0;
    captureEnd     = 1'b0;
    mode           = filterPkg::viewGray;
    outIndex       = 0;
    baseIndex      = 0;
    passCount      = 0;
    failCount      = 0;
    capturedFrames = 0;
    testName       = "startup";
    testErrors     = 0;

    cycles = 0;
    while (rstN !== 1'b1 && cycles < 20)
    begin
      @(posedge D5M_PIXLCLK);
      cycles++;
    end
    #(driveDelay);

    beginTest("resetState");
    if (rstN !== 1'b1)
    begin
      $display("%s: reset was never released", testName);
      testErrors++;
    end
    checkValue("viewValid", 0, int'(viewValid));
    checkValue("capturing", 0, int'(capturing));
    checkValue("frameTotal", 0, int'(frameTotal));
    endTest();

    // No start request yet
    runFrame("uncapturedFrame", filterPkg::viewGray, 1'b0, 1'b0);

    pulseStart();
    runFrame("grayView", filterPkg::viewGray, 1'b1, 1'b0);
    runFrame("gaussView", filterPkg::viewGauss, 1'b1, 1'b0);
    runFrame("vertEdgeView", filterPkg::viewVertEdge, 1'b1, 1'b0);
    runFrame("horizEdgeView", filterPkg::viewHorizEdge, 1'b1, 1'b0);
    runFrame("bothEdgeView", filterPkg::viewBothEdge, 1'b1, 1'b0);
    runFrame("laplaceView", filterPkg::viewLaplace, 1'b1, 1'b0);

    // Frame in progress completes and the next one is ignored
    runFrame("captureEndFrame", filterPkg::viewGauss, 1'b1, 1'b1);
    runFrame("afterCaptureEnd", filterPkg::viewGray, 1'b0, 1'b0);

    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- sim/pixelClockGen.sv
/*
  Testbench clock and reset source. Drives the 200 ns pixel clock
  and holds the active low reset for the first four cycles.
*/
`timescale 1ns/1ps

module pixelClockGen #(
  parameter int halfPeriod  = 100,
  parameter int resetCycles = 4
) (
  output logic D5M_PIXLCLK,
  output logic rstN
);

  initial
  begin
    D5M_PIXLCLK = 1'b0;
    forever #(halfPeriod) D5M_PIXLCLK = ~D5M_PIXLCLK;
  end

  // Release just after an edge
  initial
  begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge D5M_PIXLCLK);
    #10 rstN = 1'b1;
  end

endmodule

//--- vlog.f
logic/sensorPkg.sv
logic/filterPkg.sv
logic/frameCapture.sv
logic/bayerGray.sv
logic/windowBuffer.sv
logic/gaussianBlur.sv
logic/edgeLaplace.sv
logic/cameraFilterTop.sv
sim/pixelClockGen.sv
sim/cameraFilterTb.sv
